// File: source/pixel_pkg.sv
package pixel_pkg;

  // PC message word
  localparam int msg_width    = 32;
  localparam int sample_width = 20;

  localparam logic [1:0] tag_pixel = 2'd0; // may start a pixel word
  localparam logic [1:0] tag_last  = 2'd1; // final burst of a coefficient table

  // memory application interface
  localparam int burst_words     = 8;  // two 128-bit beats
  localparam int burst_cnt_width = $clog2(burst_words);
  localparam int app_data_width  = 128;
  localparam int addr_width      = 27;
  localparam logic [addr_width-1:0] start_addr = '0;
  localparam logic [addr_width-1:0] addr_inc   = 27'd8; // BL8 step

  // message queues
  localparam int fifo_depth     = 16;
  localparam int fifo_almost    = 12;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

  // pixel tracker
  localparam int col_width   = 12;
  localparam int row_width   = 12;
  localparam int frame_width = 20;
  localparam int sum_width   = 32;

  typedef enum logic [2:0] {msg_wait, wr_wait, wr1, wr2, error} writer_state_e;

  typedef enum logic [1:0] {standby, interframe, intraline, interline} tracker_state_e;

  // one word, read as coefficient data or as a camera sample
  typedef union packed {
    struct packed {
      logic [msg_width-3:0] payload;
      logic [1:0]           tag;
    } coeff;
    struct packed {
      logic [sample_width-1:0] sample;
      logic [5:0]              unused_hi;
      logic                    fval;
      logic                    lval;
      logic [1:0]              unused_lo;
      logic [1:0]              tag;
    } pixel;
  } msg_word_u;

endpackage

// File: source/msg_fifo.sv
module msg_fifo (
  input  logic                 bus_clk,
  input  logic                 fds_val,
  input  logic                 push,
  input  pixel_pkg::msg_word_u din,
  input  logic                 pop,
  output pixel_pkg::msg_word_u dout,
  output logic                 empty,
  output logic                 almost_full
);

  pixel_pkg::msg_word_u mem [pixel_pkg::fifo_depth];

  logic [pixel_pkg::fifo_ptr_width-1:0] wr_ptr;
  logic [pixel_pkg::fifo_ptr_width-1:0] rd_ptr;
  logic [pixel_pkg::fifo_cnt_width-1:0] count; // occupancy

  assign dout        = mem[rd_ptr]; // head shows through while not empty
  assign empty       = (count == '0);
  assign almost_full = (count >= pixel_pkg::fifo_cnt_width'(pixel_pkg::fifo_almost));

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, pointers wrap
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (push)
      mem[wr_ptr] <= din;
  end

endmodule

// File: source/msg_router.sv
module msg_router (
  input  logic                 bus_clk,
  input  logic                 fds_val,
  input  logic                 pc_msg_empty,
  input  pixel_pkg::msg_word_u pc_msg,
  output logic                 pc_msg_ack,
  input  logic                 pixel_full,
  input  logic                 coeff_full,
  output logic                 pixel_push,
  output logic                 coeff_push,
  output pixel_pkg::msg_word_u word
);

  // words of the current coefficient burst already routed
  logic [pixel_pkg::burst_cnt_width-1:0] coeff_cnt;
  logic is_pixel;

  // either queue nearly full stalls the whole input stream
  assign pc_msg_ack = !pc_msg_empty && !pixel_full && !coeff_full;

  // a started burst keeps every word until it has all eight
  assign is_pixel = (pc_msg.coeff.tag == pixel_pkg::tag_pixel) && (coeff_cnt == '0);

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      coeff_cnt  <= '0;
      pixel_push <= 1'b0;
      coeff_push <= 1'b0;
    end else begin
      pixel_push <= pc_msg_ack && is_pixel;
      coeff_push <= pc_msg_ack && !is_pixel;
      if (pc_msg_ack && !is_pixel)
        coeff_cnt <= coeff_cnt + 1'b1; // wraps at burst_words
    end
  end

  // payload follows the push by the same one-cycle delay
  always_ff @(posedge bus_clk) begin
    if (pc_msg_ack)
      word <= pc_msg;
  end

endmodule

// File: source/coeff_writer.sv
module coeff_writer (
  input  logic                                 bus_clk,
  input  logic                                 fds_val,
  input  logic                                 coeff_empty,
  input  pixel_pkg::msg_word_u                 coeff_word,
  output logic                                 coeff_pop,
  input  logic                                 app_rdy,
  input  logic                                 app_wdf_rdy,
  output logic                                 app_en,
  output logic [pixel_pkg::addr_width-1:0]     app_addr,
  output logic                                 app_wdf_wren,
  output logic                                 app_wdf_end,
  output logic [pixel_pkg::app_data_width-1:0] app_wdf_data,
  output logic                                 coeff_loaded,
  output logic                                 error
);

  pixel_pkg::writer_state_e state;

  // both beats of one burst with word 0 in the low bits
  logic [2*pixel_pkg::app_data_width-1:0] stage;
  logic [pixel_pkg::burst_cnt_width-1:0]  word_off;
  pixel_pkg::msg_word_u                   last_word;

  // the eighth word sits at the top of the staging register
  assign last_word = stage[2*pixel_pkg::app_data_width-1 -: pixel_pkg::msg_width];

  // one word per cycle while gathering
  assign coeff_pop = (state == pixel_pkg::msg_wait) && !coeff_empty;
  assign error     = (state == pixel_pkg::error);

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state        <= pixel_pkg::msg_wait;
      word_off     <= '0;
      app_en       <= 1'b0;
      app_addr     <= pixel_pkg::start_addr;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b1; // idles high between bursts
      coeff_loaded <= 1'b0;
    end else begin
      case (state)
        pixel_pkg::msg_wait: begin
          if (!coeff_empty) begin
            word_off <= word_off + 1'b1; // wraps back to 0 after the eighth word
            if (word_off == pixel_pkg::burst_cnt_width'(pixel_pkg::burst_words - 1)) begin
              app_en       <= 1'b1;
              coeff_loaded <= 1'b0; // a new table is on its way
              state        <= pixel_pkg::wr_wait;
            end
          end
        end

        pixel_pkg::wr_wait: begin
          // command and first beat go together
          if (app_rdy && app_wdf_rdy) begin
            app_en       <= 1'b0;
            app_addr     <= app_addr + pixel_pkg::addr_inc; // next burst
            app_wdf_wren <= 1'b1;
            app_wdf_end  <= 1'b0;
            state        <= pixel_pkg::wr1;
          end
        end

        pixel_pkg::wr1: begin
          if (app_wdf_rdy) begin
            app_wdf_end <= 1'b1;
            state       <= pixel_pkg::wr2;
          end
        end

        pixel_pkg::wr2: begin
          app_wdf_wren <= 1'b0;
          if (!app_wdf_rdy) begin
            state <= pixel_pkg::error; // second beat was not taken
          end else begin
            if (last_word.coeff.tag == pixel_pkg::tag_last) begin
              app_addr     <= pixel_pkg::start_addr; // table complete so rewind
              coeff_loaded <= 1'b1;
            end
            state <= pixel_pkg::msg_wait;
          end
        end

        default: begin
          // sticky until reset
          app_en       <= 1'b0;
          app_wdf_wren <= 1'b0;
        end
      endcase
    end
  end

  // payload path
  always_ff @(posedge bus_clk) begin
    if (coeff_pop)
      stage[word_off*pixel_pkg::msg_width +: pixel_pkg::msg_width] <= coeff_word;
    if (state == pixel_pkg::wr_wait && app_rdy && app_wdf_rdy)
      app_wdf_data <= stage[0 +: pixel_pkg::app_data_width];
    else if (state == pixel_pkg::wr1 && app_wdf_rdy)
      app_wdf_data <= stage[pixel_pkg::app_data_width +: pixel_pkg::app_data_width];
  end

endmodule

// File: source/pixel_tracker.sv
module pixel_tracker (
  input  logic                              bus_clk,
  input  logic                              fds_val,
  input  logic                              pixel_empty,
  input  pixel_pkg::msg_word_u              pixel_word,
  output logic                              pixel_pop,
  output logic                              line_valid,
  output logic [pixel_pkg::sum_width-1:0]   line_sum,
  output logic [pixel_pkg::row_width-1:0]   line_row,
  output logic [pixel_pkg::col_width-1:0]   line_len,
  output logic [pixel_pkg::frame_width-1:0] frame_count
);

  pixel_pkg::tracker_state_e state;

  logic [pixel_pkg::row_width-1:0] row;
  logic [pixel_pkg::col_width-1:0] col;  // samples seen in the current line
  logic [pixel_pkg::sum_width-1:0] sum;
  logic [pixel_pkg::sum_width-1:0] sample;
  logic fval, lval;

  assign fval   = pixel_word.pixel.fval;
  assign lval   = pixel_word.pixel.lval;
  assign sample = pixel_pkg::sum_width'(pixel_word.pixel.sample);

  // camera data cannot be stalled, take every word as it appears
  assign pixel_pop = !pixel_empty;

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state       <= pixel_pkg::standby;
      row         <= '0;
      col         <= '0;
      frame_count <= '0;
      line_valid  <= 1'b0;
    end else begin
      line_valid <= 1'b0;
      if (pixel_pop) begin
        case (state)
          pixel_pkg::standby:
            if (!fval)
              state <= pixel_pkg::interframe; // sync to a frame gap first
          pixel_pkg::interframe:
            if (lval) begin
              row   <= '0;
              col   <= 1;
              state <= pixel_pkg::intraline;
            end
          pixel_pkg::intraline:
            if (lval) begin
              col <= col + 1'b1;
            end else begin
              line_valid <= 1'b1;
              if (fval) begin
                row   <= row + 1'b1;
                state <= pixel_pkg::interline;
              end else begin
                frame_count <= frame_count + 1'b1;
                state       <= pixel_pkg::interframe;
              end
            end
          default:
            if (lval) begin // interline, next row already counted
              col   <= 1;
              state <= pixel_pkg::intraline;
            end
        endcase
      end
    end
  end

  // running sum and the result registers held between pulses
  always_ff @(posedge bus_clk) begin
    if (pixel_pop && lval) begin
      if (state == pixel_pkg::intraline)
        sum <= sum + sample;
      else if (state != pixel_pkg::standby)
        sum <= sample; // first sample of a line
    end
    if (pixel_pop && !lval && state == pixel_pkg::intraline) begin
      line_sum <= sum;
      line_row <= row;
      line_len <= col;
    end
  end

endmodule

// File: source/frame_grabber_top.sv
module frame_grabber_top (
  input  logic                                 bus_clk,
  input  logic                                 fds_val,
  input  logic                                 pc_msg_empty,
  input  logic [pixel_pkg::msg_width-1:0]      pc_msg,
  output logic                                 pc_msg_ack,
  input  logic                                 app_rdy,
  input  logic                                 app_wdf_rdy,
  output logic                                 app_en,
  output logic [pixel_pkg::addr_width-1:0]     app_addr,
  output logic                                 app_wdf_wren,
  output logic                                 app_wdf_end,
  output logic [pixel_pkg::app_data_width-1:0] app_wdf_data,
  output logic                                 coeff_loaded,
  output logic                                 error,
  output logic                                 line_valid,
  output logic [pixel_pkg::sum_width-1:0]      line_sum,
  output logic [pixel_pkg::row_width-1:0]      line_row,
  output logic [pixel_pkg::col_width-1:0]      line_len,
  output logic [pixel_pkg::frame_width-1:0]    frame_count
);

  pixel_pkg::msg_word_u routed_word;
  pixel_pkg::msg_word_u pixel_word;
  pixel_pkg::msg_word_u coeff_word;
  logic pixel_push, coeff_push;
  logic pixel_pop, coeff_pop;
  logic pixel_empty, coeff_empty;
  logic pixel_full, coeff_full; // almost-full, used as back-pressure

  msg_router router (
    .bus_clk      (bus_clk),
    .fds_val      (fds_val),
    .pc_msg_empty (pc_msg_empty),
    .pc_msg       (pc_msg),
    .pc_msg_ack   (pc_msg_ack),
    .pixel_full   (pixel_full),
    .coeff_full   (coeff_full),
    .pixel_push   (pixel_push),
    .coeff_push   (coeff_push),
    .word         (routed_word)
  );

  msg_fifo pixel_fifo (
    .bus_clk     (bus_clk),
    .fds_val     (fds_val),
    .push        (pixel_push),
    .din         (routed_word),
    .pop         (pixel_pop),
    .dout        (pixel_word),
    .empty       (pixel_empty),
    .almost_full (pixel_full)
  );

  msg_fifo coeff_fifo (
    .bus_clk     (bus_clk),
    .fds_val     (fds_val),
    .push        (coeff_push),
    .din         (routed_word),
    .pop         (coeff_pop),
    .dout        (coeff_word),
    .empty       (coeff_empty),
    .almost_full (coeff_full)
  );

  coeff_writer writer (
    .bus_clk      (bus_clk),
    .fds_val      (fds_val),
    .coeff_empty  (coeff_empty),
    .coeff_word   (coeff_word),
    .coeff_pop    (coeff_pop),
    .app_rdy      (app_rdy),
    .app_wdf_rdy  (app_wdf_rdy),
    .app_en       (app_en),
    .app_addr     (app_addr),
    .app_wdf_wren (app_wdf_wren),
    .app_wdf_end  (app_wdf_end),
    .app_wdf_data (app_wdf_data),
    .coeff_loaded (coeff_loaded),
    .error        (error)
  );

  pixel_tracker tracker (
    .bus_clk     (bus_clk),
    .fds_val     (fds_val),
    .pixel_empty (pixel_empty),
    .pixel_word  (pixel_word),
    .pixel_pop   (pixel_pop),
    .line_valid  (line_valid),
    .line_sum    (line_sum),
    .line_row    (line_row),
    .line_len    (line_len),
    .frame_count (frame_count)
  );

endmodule

// File: verification/frame_grabber_tb.sv
module frame_grabber_tb;

  localparam int max_words  = 256;
  localparam int max_lines  = 32;
  localparam int max_writes = 16;

  logic                                 bus_clk;
  logic                                 fds_val;
  logic                                 pc_msg_empty;
  logic [pixel_pkg::msg_width-1:0]      pc_msg;
  logic                                 pc_msg_ack;
  logic                                 app_rdy;
  logic                                 app_wdf_rdy;
  logic                                 app_en;
  logic [pixel_pkg::addr_width-1:0]     app_addr;
  logic                                 app_wdf_wren;
  logic                                 app_wdf_end;
  logic [pixel_pkg::app_data_width-1:0] app_wdf_data;
  logic                                 coeff_loaded;
  logic                                 error;
  logic                                 line_valid;
  logic [pixel_pkg::sum_width-1:0]      line_sum;
  logic [pixel_pkg::row_width-1:0]      line_row;
  logic [pixel_pkg::col_width-1:0]      line_len;
  logic [pixel_pkg::frame_width-1:0]    frame_count;

  // input words, applied in order
  logic [pixel_pkg::msg_width-1:0]      stim_word [max_words];
  int                                   stim_len = 0;

  // expected line results and memory writes
  logic [pixel_pkg::sum_width-1:0]      exp_sum   [max_lines];
  logic [pixel_pkg::row_width-1:0]      exp_row   [max_lines];
  logic [pixel_pkg::col_width-1:0]      exp_len   [max_lines];
  logic [pixel_pkg::frame_width-1:0]    exp_frame [max_lines];
  logic [pixel_pkg::addr_width-1:0]     exp_addr   [max_writes];
  logic [pixel_pkg::app_data_width-1:0] exp_beat0  [max_writes];
  logic [pixel_pkg::app_data_width-1:0] exp_beat1  [max_writes];
  logic                                 exp_loaded [max_writes];
  int line_n = 0;
  int wr_n   = 0;

  // camera and memory position while the tables are built
  logic [pixel_pkg::row_width-1:0]   cur_row   = '0;
  logic [pixel_pkg::frame_width-1:0] cur_frame = '0;
  logic [pixel_pkg::addr_width-1:0]  cur_addr  = pixel_pkg::start_addr;

  integer seed = 52474;
  int     error_count = 0;
  int     line_idx = 0;
  int     wr_idx = 0;
  int     cycle_count = 0;
  int     cycle_limit = 0;
  logic [pixel_pkg::addr_width-1:0]     got_addr = '0;
  logic [pixel_pkg::app_data_width-1:0] got_beat0 = '0;
  logic loaded_due    = 1'b0;
  logic wren_seen     = 1'b0;
  logic reset_checked = 1'b0;
  logic error_seen    = 1'b0;
  int   idx;
  logic taken;

  frame_grabber_top i_frame_grabber_top (.*);

  initial begin
    bus_clk = 1'b0;
    forever #20 bus_clk = ~bus_clk;
  end

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic print_summary();
    $display("errors %0d, lines %0d of %0d, writes %0d of %0d",
             error_count, line_idx, line_n, wr_idx, wr_n);
  endtask

  function automatic logic [31:0] pixel_word(input logic [19:0] sample, input logic fval,
                                             input logic lval);
    return {sample, 6'b0, fval, lval, 2'b00, pixel_pkg::tag_pixel};
  endfunction

  task automatic add_word(input logic [31:0] w);
    stim_word[stim_len] = w;
    stim_len++;
  endtask

  // lval low, its sample must not count
  task automatic add_gap(input logic fval);
    add_word(pixel_word(20'($random(seed)), fval, 1'b0));
  endtask

  task automatic add_line(input int len, input logic frame_ends);
    logic [19:0] sample;
    logic [31:0] sum;
    sum = '0;
    for (int k = 0; k < len; k++) begin
      sample = 20'($random(seed));
      sum = sum + 32'(sample);
      add_word(pixel_word(sample, 1'b1, 1'b1));
    end
    add_word(pixel_word(20'($random(seed)), !frame_ends, 1'b0)); // ends the line
    if (frame_ends)
      cur_frame++; // counted at the same edge as the pulse
    exp_sum[line_n]   = sum;
    exp_row[line_n]   = cur_row;
    exp_len[line_n]   = pixel_pkg::col_width'(len);
    exp_frame[line_n] = cur_frame;
    line_n++;
    if (frame_ends)
      cur_row = '0;
    else
      cur_row++;
  endtask

  task automatic add_burst(input logic table_end);
    logic [31:0] w [8];
    logic [1:0]  tag;
    for (int k = 0; k < pixel_pkg::burst_words; k++) begin
      if (k == 0)
        tag = 2'd2; // must not look like a pixel word
      else if (k == 7)
        tag = table_end ? pixel_pkg::tag_last : 2'd3;
      else
        tag = 2'(k); // tag 0 and tag 1 inside the burst too
      w[k] = {30'($random(seed)), tag};
      add_word(w[k]);
    end
    exp_addr[wr_n]   = cur_addr;
    exp_beat0[wr_n]  = {w[3], w[2], w[1], w[0]};
    exp_beat1[wr_n]  = {w[7], w[6], w[5], w[4]};
    exp_loaded[wr_n] = table_end;
    wr_n++;
    cur_addr = table_end ? pixel_pkg::start_addr : cur_addr + pixel_pkg::addr_inc;
  endtask

  task automatic build_tables();
    add_gap(1'b0);
    add_gap(1'b0);
    add_line(3, 1'b0); // frame 1, rows 0..2
    add_gap(1'b1);
    add_line(5, 1'b0);
    add_line(2, 1'b1);
    add_gap(1'b0);
    add_burst(1'b0);
    add_line(4, 1'b0); // frame 2
    add_line(1, 1'b1);
    add_gap(1'b0);
    add_burst(1'b1);   // table end, address rewinds
    add_line(6, 1'b0); // frame 3 starts at row 0
    add_gap(1'b1);
    add_burst(1'b0);
    add_line(2, 1'b0);
    add_line(7, 1'b1);
    add_burst(1'b0);
    add_burst(1'b0);
    add_burst(1'b1);
    add_gap(1'b0);
    add_line(3, 1'b0);
    add_line(1, 1'b1);
    cycle_limit = 40 * stim_len + 2000;
  endtask

  // memory side, random ready until a write is under way
  always @(posedge bus_clk) begin
    if (fds_val) begin
      app_rdy     <= 1'b0;
      app_wdf_rdy <= 1'b0;
    end else begin
      app_rdy     <= 1'($random(seed));
      app_wdf_rdy <= wren_seen ? 1'b1 : 1'($random(seed));
    end
  end

  always @(negedge bus_clk) begin
    wren_seen = app_wdf_wren;
    if (!fds_val && !reset_checked) begin
      check_value("reset pc_msg_ack", '0, 128'(pc_msg_ack));
      check_value("reset app_en", '0, 128'(app_en));
      check_value("reset app_wdf_wren", '0, 128'(app_wdf_wren));
      check_value("reset app_wdf_end", 128'(1), 128'(app_wdf_end));
      check_value("reset line_valid", '0, 128'(line_valid));
      check_value("reset coeff_loaded", '0, 128'(coeff_loaded));
      check_value("reset error", '0, 128'(error));
      reset_checked = 1'b1;
    end else if (!fds_val) begin
      if (line_valid) begin
        if (line_idx < line_n) begin
          check_value($sformatf("line %0d sum", line_idx), 128'(exp_sum[line_idx]),
                      128'(line_sum));
          check_value($sformatf("line %0d row", line_idx), 128'(exp_row[line_idx]),
                      128'(line_row));
          check_value($sformatf("line %0d length", line_idx), 128'(exp_len[line_idx]),
                      128'(line_len));
          check_value($sformatf("line %0d frame count", line_idx),
                      128'(exp_frame[line_idx]), 128'(frame_count));
        end else begin
          error_count++;
          $display("line_valid pulsed after all %0d expected lines", line_n);
        end
        line_idx++;
      end
      if (loaded_due) begin
        check_value($sformatf("write %0d coeff_loaded", wr_idx - 1),
                    128'(exp_loaded[wr_idx-1]), 128'(coeff_loaded));
        loaded_due = 1'b0;
      end
      if (app_en) begin
        check_value("coeff_loaded while a command waits", '0, 128'(coeff_loaded));
        if (app_rdy && app_wdf_rdy)
          got_addr = app_addr; // command taken at the next edge
      end
      if (app_wdf_wren && !app_wdf_end)
        got_beat0 = app_wdf_data;
      if (app_wdf_wren && app_wdf_end) begin
        if (wr_idx < wr_n) begin
          check_value($sformatf("write %0d address", wr_idx), 128'(exp_addr[wr_idx]),
                      128'(got_addr));
          check_value($sformatf("write %0d beat 0", wr_idx), exp_beat0[wr_idx], got_beat0);
          check_value($sformatf("write %0d beat 1", wr_idx), exp_beat1[wr_idx],
                      app_wdf_data);
          loaded_due = 1'b1;
        end else begin
          error_count++;
          $display("memory write seen after all %0d expected writes", wr_n);
        end
        wr_idx++;
      end
      if (error && !error_seen) begin
        check_value("writer error flag", '0, 128'(error));
        error_seen = 1'b1;
      end
    end
  end

  always @(posedge bus_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the expected results did not all arrive",
               cycle_count);
      print_summary();
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    fds_val      = 1'b1;
    pc_msg_empty = 1'b1;
    pc_msg       = '0;
    app_rdy      = 1'b0;
    app_wdf_rdy  = 1'b0;
    build_tables();
    repeat (8) @(posedge bus_clk);
    fds_val <= 1'b0;
    @(posedge bus_clk);
    pc_msg_empty <= 1'b0;
    pc_msg       <= stim_word[0];
    idx = 0;
    while (idx < stim_len) begin
      @(negedge bus_clk);
      taken = pc_msg_ack;
      @(posedge bus_clk);
      if (taken) begin
        idx++;
        if (idx < stim_len)
          pc_msg <= stim_word[idx];
        else
          pc_msg_empty <= 1'b1;
      end
    end
    while (line_idx < line_n || wr_idx < wr_n)
      @(posedge bus_clk);
    repeat (20) @(posedge bus_clk); // catch stray pulses and the last coeff_loaded
    print_summary();
    if (error_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: compile.f
source/pixel_pkg.sv
source/msg_fifo.sv
source/msg_router.sv
source/coeff_writer.sv
source/pixel_tracker.sv
source/frame_grabber_top.sv
verification/frame_grabber_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f compile.f --top-module frame_grabber_tb \
    -Mdir obj_dir -o frame_grabber_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/frame_grabber_sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
